//--- build.f
logic/vrf_pkg.sv
logic/vrf_beat_counter.sv
logic/vrf_sequencer_fsm.sv
logic/vrf_operand_regs.sv
logic/vrf_interface.sv
verification/vrf_mem_responder.sv
verification/vrf_interface_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the operand sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM=vrf_sim

verilator --binary --timing --assert -Wno-fatal \
  --top-module vrf_interface_tb -f build.f \
  --Mdir "$BUILD_DIR" -o "$SIM"
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
exit 0

//--- verification/vrf_interface_tb.sv
`timescale 1ns/1ps

module vrf_interface_tb import vrf_pkg::*; ();

  localparam int unsigned NUM_OPS         = 40;
  localparam int unsigned RESET_CYCLES    = 16;
  localparam int unsigned REGION_WORDS    = 64;
  localparam int unsigned RS1_BASE        = 0;
  localparam int unsigned RS2_BASE        = 64;
  localparam int unsigned RD_BASE         = 128;
  localparam int unsigned MEM_DEPTH       = 192;
  localparam int          SEED            = 27;
  localparam int unsigned WATCHDOG_CYCLES = RESET_CYCLES + NUM_OPS * 400;

  // Operation kinds
  localparam int OP_UNARY  = 0;
  localparam int OP_BINARY = 1;
  localparam int OP_FILL   = 2;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      req_i;
  logic                      sel_rs1_i;
  logic                      sel_rs2_i;
  logic                      sel_rd_i;
  sew_e                      sew_i;
  logic [VL_BITS-1:0]        vl_i;
  logic [WORD_BITS-1:0]      wdata_i;
  logic [WORD_BITS-1:0]      rdata_a_o;
  logic [WORD_BITS-1:0]      rdata_b_o;
  logic                      vector_done_o;
  logic                      data_req_o;
  logic                      data_we_o;
  logic [BYTES_PER_WORD-1:0] data_be_o;
  logic [WORD_BITS-1:0]      data_wdata_o;
  logic                      data_gnt_i;
  logic                      data_rvalid_i;
  logic [WORD_BITS-1:0]      data_rdata_i;
  logic                      agu_load_o;
  logic                      agu_get_rs1_o;
  logic                      agu_get_rs2_o;
  logic                      agu_get_rd_o;
  logic                      agu_incr_o;

  integer                    seed;
  int unsigned               error_count;
  int unsigned               op_count;
  int unsigned               done_count;
  int unsigned               write_count;
  int unsigned               bus_count;
  int                        op_kind;
  logic [WORD_BITS-1:0]      fill_pattern;
  logic [WORD_BITS-1:0]      ref_mem [MEM_DEPTH];

  // Request seen in the previous cycle
  logic                      prev_stall;
  logic                      prev_we;
  logic [BYTES_PER_WORD-1:0] prev_be;
  logic [WORD_BITS-1:0]      prev_wdata;

  vrf_interface DUT (.*);

  vrf_mem_responder #(
    .MEM_DEPTH (MEM_DEPTH),
    .RS1_BASE  (RS1_BASE),
    .RS2_BASE  (RS2_BASE),
    .RD_BASE   (RD_BASE),
    .SEED      (SEED)
  ) u_mem (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req_o),
    .data_we_i     (data_we_o),
    .data_be_i     (data_be_o),
    .data_wdata_i  (data_wdata_o),
    .data_gnt_o    (data_gnt_i),
    .data_rvalid_o (data_rvalid_i),
    .data_rdata_o  (data_rdata_i),
    .agu_load_i    (agu_load_o),
    .agu_get_rs1_i (agu_get_rs1_o),
    .agu_get_rs2_i (agu_get_rs2_o),
    .agu_get_rd_i  (agu_get_rd_o),
    .agu_incr_i    (agu_incr_o)
  );

  always #50 clk_i = ~clk_i;

  // ALU in front of the write port
  always_comb begin
    case (op_kind)
      OP_UNARY:  wdata_i = ~rdata_b_o;
      OP_BINARY: wdata_i = rdata_a_o + rdata_b_o;
      default:   wdata_i = fill_pattern;
    endcase
  end

  task automatic report_mismatch(input string name, input logic [WORD_BITS-1:0] expected,
                                 input logic [WORD_BITS-1:0] actual);
    error_count++;
    $display("FAILED at %0t: %s expected 0x%08h, actual 0x%08h", $time, name, expected, actual);
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  ////////////////////////////////////////
  // Bus monitor
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (data_req_o && ($countones({agu_get_rs1_o, agu_get_rs2_o, agu_get_rd_o}) != 1)) begin
        report_error("request without exactly one address select");
      end
      if (agu_incr_o !== (data_req_o && data_gnt_i)) begin
        report_mismatch("agu_incr_o", 32'(data_req_o && data_gnt_i), 32'(agu_incr_o));
      end
      // Ungranted request must come back unchanged
      if (prev_stall) begin
        if (data_req_o !== 1'b1) begin
          report_mismatch("data_req_o", 32'(1'b1), 32'(data_req_o));
        end
        if (data_we_o !== prev_we) begin
          report_mismatch("data_we_o", 32'(prev_we), 32'(data_we_o));
        end
        if (prev_we && (data_be_o !== prev_be)) begin
          report_mismatch("data_be_o", 32'(prev_be), 32'(data_be_o));
        end
        if (prev_we && (data_wdata_o !== prev_wdata)) begin
          report_mismatch("data_wdata_o", prev_wdata, data_wdata_o);
        end
      end
      prev_stall = data_req_o && !data_gnt_i;
      prev_we    = data_we_o;
      prev_be    = data_be_o;
      prev_wdata = data_wdata_o;
      if (data_req_o && data_we_o && data_gnt_i) begin
        write_count++;
      end
      if (vector_done_o) begin
        done_count++;
      end
      if (data_req_o || agu_load_o || agu_get_rs1_o || agu_get_rs2_o || agu_get_rd_o
          || agu_incr_o) begin
        bus_count++;
      end
    end
  end

  ////////////////////////////////////////
  // Reference model and operations
  ////////////////////////////////////////

  task automatic update_reference(input int kind, input int unsigned src_base,
                                  input int nbytes, input int beats);
    int                   w;
    int                   b;
    logic [WORD_BITS-1:0] result;

    for (w = 0; w < beats; w++) begin
      case (kind)
        OP_UNARY:  result = ~ref_mem[src_base + w];
        OP_BINARY: result = ref_mem[RS1_BASE + w] + ref_mem[RS2_BASE + w];
        default:   result = fill_pattern;
      endcase
      // bytes past vl keep their old value
      for (b = 0; b < BYTES_PER_WORD; b++) begin
        if (w * BYTES_PER_WORD + b < nbytes) begin
          ref_mem[RD_BASE + w][8*b +: 8] = result[8*b +: 8];
        end
      end
    end
  endtask

  task automatic run_op(input int index);
    int                   kind;
    int                   sew_sel;
    int                   vl;
    int                   nbytes;
    int                   beats;
    int                   cycles;
    int                   w;
    int unsigned          src_base;
    logic                 use_rs1;
    logic [WORD_BITS-1:0] rand_word;

    // Every kind at every sew first, then random
    kind      = (index < 9) ? index % 3 : $unsigned($random(seed)) % 3;
    sew_sel   = (index < 9) ? index / 3 : $unsigned($random(seed)) % 3;
    vl        = (index % 10 == 9) ? 0 : $unsigned($random(seed)) % 41;
    rand_word = $random(seed);
    use_rs1   = rand_word[0];
    src_base  = use_rs1 ? RS1_BASE : RS2_BASE;

    // Fresh source words for every vector
    for (w = 0; w < REGION_WORDS; w++) begin
      ref_mem[RS1_BASE + w]   = $random(seed);
      ref_mem[RS2_BASE + w]   = $random(seed);
      u_mem.mem[RS1_BASE + w] = ref_mem[RS1_BASE + w];
      u_mem.mem[RS2_BASE + w] = ref_mem[RS2_BASE + w];
    end
    fill_pattern = $random(seed);

    nbytes = vl << sew_sel;
    beats  = (nbytes + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
    update_reference(kind, src_base, nbytes, beats);

    @(posedge clk_i);
    #1;
    op_kind     = kind;
    sel_rs1_i   = (kind == OP_BINARY) || (kind == OP_UNARY && use_rs1);
    sel_rs2_i   = (kind == OP_BINARY) || (kind == OP_UNARY && !use_rs1);
    sel_rd_i    = 1'b1;
    sew_i       = sew_e'(sew_sel);
    vl_i        = vl;
    done_count  = 0;
    write_count = 0;
    bus_count   = 0;
    cycles      = 0;
    req_i       = 1'b1;

    do begin
      @(negedge clk_i);
      cycles++;
    end while (vector_done_o !== 1'b1);

    @(posedge clk_i);
    #1;
    req_i = 1'b0;

    if (done_count != 1) begin
      report_mismatch("vector_done_o pulses", 1, done_count);
    end
    if (write_count != beats) begin
      report_mismatch("granted writes", beats, write_count);
    end
    if (vl == 0 && cycles != 1) begin
      report_mismatch("vector_done_o latency", 1, cycles);
    end
    if (vl == 0 && bus_count != 0) begin
      report_error("bus or address generator strobe during an empty vector");
    end
    for (w = 0; w < MEM_DEPTH; w++) begin
      if (u_mem.mem[w] !== ref_mem[w]) begin
        report_mismatch($sformatf("mem[%0d]", w), ref_mem[w], u_mem.mem[w]);
      end
    end
    op_count++;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int       i;
    logic [7:0] idle_strobes;

    $timeformat(-9, 0, " ns", 0);
    seed         = SEED;
    error_count  = 0;
    op_count     = 0;
    done_count   = 0;
    write_count  = 0;
    bus_count    = 0;
    op_kind      = OP_FILL;
    fill_pattern = '0;
    prev_stall   = 1'b0;
    prev_we      = 1'b0;
    prev_be      = '0;
    prev_wdata   = '0;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    req_i        = 1'b0;
    sel_rs1_i    = 1'b0;
    sel_rs2_i    = 1'b0;
    sel_rd_i     = 1'b0;
    sew_i        = SEW_8;
    vl_i         = '0;
    for (i = 0; i < MEM_DEPTH; i++) begin
      ref_mem[i]   = $random(seed);
      u_mem.mem[i] = ref_mem[i];
    end

    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Quiet bus before the first request
    repeat (4) begin
      @(negedge clk_i);
      idle_strobes = {data_req_o, data_we_o, agu_load_o, agu_get_rs1_o, agu_get_rs2_o,
                      agu_get_rd_o, agu_incr_o, vector_done_o};
      if (idle_strobes !== 8'b0) begin
        report_mismatch("strobes after reset", '0, 32'(idle_strobes));
      end
    end

    for (i = 0; i < NUM_OPS; i++) begin
      run_op(i);
    end

    $display("Operations: %0d, errors: %0d", op_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog sized from the number of operations
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, an operation never finished", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- verification/vrf_mem_responder.sv
`timescale 1ns/1ps

module vrf_mem_responder import vrf_pkg::*; #(
  parameter int unsigned MEM_DEPTH = 192,
  parameter int unsigned RS1_BASE  = 0,
  parameter int unsigned RS2_BASE  = 64,
  parameter int unsigned RD_BASE   = 128,
  parameter int          SEED      = 27
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      data_req_i,
  input  logic                      data_we_i,
  input  logic [BYTES_PER_WORD-1:0] data_be_i,
  input  logic [WORD_BITS-1:0]      data_wdata_i,
  output logic                      data_gnt_o,
  output logic                      data_rvalid_o,
  output logic [WORD_BITS-1:0]      data_rdata_o,
  input  logic                      agu_load_i,
  input  logic                      agu_get_rs1_i,
  input  logic                      agu_get_rs2_i,
  input  logic                      agu_get_rd_i,
  input  logic                      agu_incr_i
);

  logic [WORD_BITS-1:0] mem [MEM_DEPTH];

  // Pointers of the external address generator
  int unsigned rs1_ptr;
  int unsigned rs2_ptr;
  int unsigned rd_ptr;

  integer gnt_seed;

  initial begin
    logic [WORD_BITS-1:0]      rand_word;
    logic [WORD_BITS-1:0]      wdata;
    logic [BYTES_PER_WORD-1:0] be;
    logic                      fire;
    logic                      we;
    logic                      load;
    logic                      incr;
    logic                      get_rs1;
    logic                      get_rs2;
    logic                      get_rd;
    int unsigned               addr;
    int                        b;

    gnt_seed      = SEED;
    rs1_ptr       = 0;
    rs2_ptr       = 0;
    rd_ptr        = 0;
    data_gnt_o    = 1'b0;
    data_rvalid_o = 1'b0;
    data_rdata_o  = '0;

    forever begin
      // Bus sampled mid-cycle
      @(negedge clk_i);
      get_rs1 = agu_get_rs1_i;
      get_rs2 = agu_get_rs2_i;
      get_rd  = agu_get_rd_i;
      // An access without any pointer select reaches no word
      fire    = rst_ni && data_req_i && data_gnt_o && (get_rs1 || get_rs2 || get_rd);
      we      = data_we_i;
      be      = data_be_i;
      wdata   = data_wdata_i;
      load    = rst_ni && agu_load_i;
      incr    = rst_ni && agu_incr_i;
      if (get_rs1) begin
        addr = RS1_BASE + rs1_ptr;
      end else if (get_rs2) begin
        addr = RS2_BASE + rs2_ptr;
      end else begin
        addr = RD_BASE + rd_ptr;
      end

      @(posedge clk_i);
      #1;
      // Read data one cycle after its grant
      data_rvalid_o = 1'b0;
      if (fire) begin
        if (we) begin
          for (b = 0; b < BYTES_PER_WORD; b++) begin
            if (be[b]) begin
              mem[addr][8*b +: 8] = wdata[8*b +: 8];
            end
          end
        end else begin
          data_rvalid_o = 1'b1;
          data_rdata_o  = mem[addr];
        end
      end

      if (load) begin
        rs1_ptr = 0;
        rs2_ptr = 0;
        rd_ptr  = 0;
      end else if (incr) begin
        if (get_rs1) begin
          rs1_ptr++;
        end else if (get_rs2) begin
          rs2_ptr++;
        end else if (get_rd) begin
          rd_ptr++;
        end
      end

      // Grant about half the cycles
      rand_word  = $random(gnt_seed);
      data_gnt_o = rst_ni && rand_word[0];
    end
  end

endmodule

//--- logic/vrf_interface.sv
`timescale 1ns/1ps

module vrf_interface import vrf_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic                      sel_rs1_i,
  input  logic                      sel_rs2_i,
  input  logic                      sel_rd_i,
  input  sew_e                      sew_i,
  input  logic [VL_BITS-1:0]        vl_i,
  input  logic [WORD_BITS-1:0]      wdata_i,
  output logic [WORD_BITS-1:0]      rdata_a_o,
  output logic [WORD_BITS-1:0]      rdata_b_o,
  output logic                      vector_done_o,
  output logic                      data_req_o,
  output logic                      data_we_o,
  output logic [BYTES_PER_WORD-1:0] data_be_o,
  output logic [WORD_BITS-1:0]      data_wdata_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic [WORD_BITS-1:0]      data_rdata_i,
  output logic                      agu_load_o,
  output logic                      agu_get_rs1_o,
  output logic                      agu_get_rs2_o,
  output logic                      agu_get_rd_o,
  output logic                      agu_incr_o
);

  // Counter handshake
  logic load;
  logic beat_done;
  logic vl_zero;
  logic last_beat;

  // Operand register controls
  logic cap_a;
  logic cap_b;
  logic stall_write;

  vrf_beat_counter u_beat_counter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (load),
    .beat_done_i (beat_done),
    .vl_i        (vl_i),
    .sew_i       (sew_i),
    .vl_zero_o   (vl_zero),
    .last_beat_o (last_beat),
    .data_be_o   (data_be_o)
  );

  vrf_sequencer_fsm u_sequencer_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .sel_rs1_i     (sel_rs1_i),
    .sel_rs2_i     (sel_rs2_i),
    .sel_rd_i      (sel_rd_i),
    .vl_zero_i     (vl_zero),
    .last_beat_i   (last_beat),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .load_o        (load),
    .beat_done_o   (beat_done),
    .cap_a_o       (cap_a),
    .cap_b_o       (cap_b),
    .stall_write_o (stall_write),
    .vector_done_o (vector_done_o),
    .data_req_o    (data_req_o),
    .data_we_o     (data_we_o),
    .agu_load_o    (agu_load_o),
    .agu_get_rs1_o (agu_get_rs1_o),
    .agu_get_rs2_o (agu_get_rs2_o),
    .agu_get_rd_o  (agu_get_rd_o),
    .agu_incr_o    (agu_incr_o)
  );

  vrf_operand_regs u_operand_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cap_a_i       (cap_a),
    .cap_b_i       (cap_b),
    .stall_write_i (stall_write),
    .data_rdata_i  (data_rdata_i),
    .wdata_i       (wdata_i),
    .rdata_a_o     (rdata_a_o),
    .rdata_b_o     (rdata_b_o),
    .data_wdata_o  (data_wdata_o)
  );

endmodule

//--- logic/vrf_operand_regs.sv
`timescale 1ns/1ps

module vrf_operand_regs import vrf_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cap_a_i,
  input  logic                 cap_b_i,
  input  logic                 stall_write_i,
  input  logic [WORD_BITS-1:0] data_rdata_i,
  input  logic [WORD_BITS-1:0] wdata_i,
  output logic [WORD_BITS-1:0] rdata_a_o,
  output logic [WORD_BITS-1:0] rdata_b_o,
  output logic [WORD_BITS-1:0] data_wdata_o
);

  logic [WORD_BITS-1:0] op_a_q;
  logic [WORD_BITS-1:0] op_b_q;
  logic [WORD_BITS-1:0] hold_q;
  logic                 hold_sel_q;

  ////////////////////////////////////////
  // Operand registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (cap_a_i) begin
      op_a_q <= data_rdata_i;
    end
    if (cap_b_i) begin
      op_b_q <= data_rdata_i;
    end
  end

  assign rdata_a_o = op_a_q;
  assign rdata_b_o = op_b_q;

  ////////////////////////////////////////
  // Write data hold during grant stall
  ////////////////////////////////////////

  // Result sampled in the first stalled cycle, before the operands move on
  always_ff @(posedge clk_i) begin
    if (stall_write_i && !hold_sel_q) begin
      hold_q <= wdata_i;
    end
  end

  // Stays set through the granting cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_sel_q <= 1'b0;
    end else begin
      hold_sel_q <= stall_write_i;
    end
  end

  assign data_wdata_o = hold_sel_q ? hold_q : wdata_i;

  // Write data frozen from the stall up to the grant
  a_wdata_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    stall_write_i |=> $stable(data_wdata_o)
  ) else $error("write data changed while waiting for grant");

endmodule

//--- logic/vrf_sequencer_fsm.sv
`timescale 1ns/1ps

module vrf_sequencer_fsm import vrf_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_i,
  input  logic sel_rs1_i,
  input  logic sel_rs2_i,
  input  logic sel_rd_i,
  input  logic vl_zero_i,
  input  logic last_beat_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic load_o,
  output logic beat_done_o,
  output logic cap_a_o,
  output logic cap_b_o,
  output logic stall_write_o,
  output logic vector_done_o,
  output logic data_req_o,
  output logic data_we_o,
  output logic agu_load_o,
  output logic agu_get_rs1_o,
  output logic agu_get_rs2_o,
  output logic agu_get_rd_o,
  output logic agu_incr_o
);

  vrf_state_e state_q;
  vrf_state_e state_d;
  logic       first_q;
  logic       first_d;
  logic       final_q;
  logic       final_d;
  logic       binary_op;
  logic       unary_op;
  logic       fill_op;

  // Operation kind from the register selects
  assign binary_op = sel_rs1_i & sel_rs2_i & sel_rd_i;
  assign unary_op  = (sel_rs1_i ^ sel_rs2_i) & sel_rd_i;
  assign fill_op   = ~sel_rs1_i & ~sel_rs2_i & sel_rd_i;

  ////////////////////////////////////////
  // Strobes derived from the bus request
  ////////////////////////////////////////

  assign agu_load_o    = load_o;
  assign agu_incr_o    = data_req_o & data_gnt_i;
  assign beat_done_o   = data_req_o & data_we_o & data_gnt_i;
  assign stall_write_o = data_req_o & data_we_o & ~data_gnt_i;

  // Read data arrives in the first cycle of the capturing state
  assign cap_a_o = data_rvalid_i & (state_q == BIN_READ_A);
  assign cap_b_o = data_rvalid_i & ((state_q == BIN_READ_B) | (state_q == UN_READ));

  // Set once the last write of the vector is granted
  assign final_d = load_o ? 1'b0 : (final_q | (beat_done_o & last_beat_i));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      first_q <= 1'b0;
      final_q <= 1'b0;
    end else begin
      state_q <= state_d;
      first_q <= first_d;
      final_q <= final_d;
    end
  end

  ////////////////////////////////////////
  // Next state and bus requests
  ////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    first_d       = first_q;
    load_o        = 1'b0;
    vector_done_o = 1'b0;
    data_req_o    = 1'b0;
    data_we_o     = 1'b0;
    agu_get_rs1_o = 1'b0;
    agu_get_rs2_o = 1'b0;
    agu_get_rd_o  = 1'b0;

    case (state_q)
      IDLE: begin
        if (req_i) begin
          if (vl_zero_i) begin
            vector_done_o = 1'b1;
          end else begin
            load_o  = 1'b1;
            first_d = 1'b1;
            state_d = START;
          end
        end
      end

      // First source read, rs1 leads in binary mode
      START: begin
        if (binary_op || unary_op) begin
          data_req_o    = 1'b1;
          agu_get_rs1_o = sel_rs1_i;
          agu_get_rs2_o = ~sel_rs1_i;
          if (data_gnt_i) begin
            state_d = binary_op ? BIN_READ_A : UN_READ;
          end
        end else if (fill_op) begin
          state_d = FILL_WRITE;
        end else begin
          vector_done_o = 1'b1;
          state_d       = IDLE;
        end
      end

      // Capture source, write the previous result meanwhile
      UN_READ: begin
        if (first_q) begin
          first_d = 1'b0;
          state_d = UN_WRITE;
        end else begin
          data_req_o   = 1'b1;
          data_we_o    = 1'b1;
          agu_get_rd_o = 1'b1;
          if (data_gnt_i) begin
            state_d = UN_WRITE;
          end
        end
      end

      UN_WRITE: begin
        if (final_q) begin
          vector_done_o = 1'b1;
          state_d       = IDLE;
        end else if (last_beat_i) begin
          // No source word left, only the last write
          state_d = UN_READ;
        end else begin
          data_req_o    = 1'b1;
          agu_get_rs1_o = sel_rs1_i;
          agu_get_rs2_o = ~sel_rs1_i;
          if (data_gnt_i) begin
            state_d = UN_READ;
          end
        end
      end

      // Capture rs1, write the previous sum meanwhile
      BIN_READ_A: begin
        if (first_q) begin
          first_d = 1'b0;
          state_d = BIN_WRITE;
        end else begin
          data_req_o   = 1'b1;
          data_we_o    = 1'b1;
          agu_get_rd_o = 1'b1;
          if (data_gnt_i) begin
            state_d = BIN_WRITE;
          end
        end
      end

      BIN_WRITE: begin
        if (final_q) begin
          vector_done_o = 1'b1;
          state_d       = IDLE;
        end else begin
          data_req_o    = 1'b1;
          agu_get_rs2_o = 1'b1;
          if (data_gnt_i) begin
            state_d = BIN_READ_B;
          end
        end
      end

      // Capture rs2, fetch the next rs1 word
      BIN_READ_B: begin
        if (last_beat_i) begin
          state_d = BIN_READ_A;
        end else begin
          data_req_o    = 1'b1;
          agu_get_rs1_o = 1'b1;
          if (data_gnt_i) begin
            state_d = BIN_READ_A;
          end
        end
      end

      FILL_WRITE: begin
        if (final_q) begin
          vector_done_o = 1'b1;
          state_d       = IDLE;
        end else begin
          data_req_o   = 1'b1;
          data_we_o    = 1'b1;
          agu_get_rd_o = 1'b1;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  a_we_with_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    data_we_o |-> data_req_o
  ) else $error("write strobe without request");

  // Ungranted request comes back unchanged
  a_req_hold : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (data_req_o && !data_gnt_i) |=> data_req_o && $stable(data_we_o)
      && $stable({agu_get_rs1_o, agu_get_rs2_o, agu_get_rd_o})
  ) else $error("request changed before grant");

endmodule

//--- logic/vrf_beat_counter.sv
`timescale 1ns/1ps

module vrf_beat_counter import vrf_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      load_i,
  input  logic                      beat_done_i,
  input  logic [VL_BITS-1:0]        vl_i,
  input  sew_e                      sew_i,
  output logic                      vl_zero_o,
  output logic                      last_beat_o,
  output logic [BYTES_PER_WORD-1:0] data_be_o
);

  // One extra bit so a partial tail beat never wraps the count
  localparam int unsigned BEAT_BITS = VL_BITS - BYTE_OFFSET_BITS + 1;

  logic [VL_BITS-1:0]          byte_count;
  logic [BYTE_OFFSET_BITS-1:0] tail_d;
  logic [BYTE_OFFSET_BITS-1:0] tail_q;
  logic [BEAT_BITS-1:0]        beats_d;
  logic [BEAT_BITS-1:0]        beats_q;
  logic [BYTES_PER_WORD-1:0]   tail_be;

  ////////////////////////////////////////
  // Beat count from vl and sew
  ////////////////////////////////////////

  assign byte_count = vl_i << sew_i;
  assign tail_d     = byte_count[BYTE_OFFSET_BITS-1:0];

  // Whole words, plus one for a partial tail word
  assign beats_d = BEAT_BITS'(byte_count[VL_BITS-1:BYTE_OFFSET_BITS])
                 + BEAT_BITS'(|tail_d);

  // Empty vector, no beats at all
  assign vl_zero_o = (byte_count == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beats_q <= '0;
      tail_q  <= '0;
    end else if (load_i) begin
      beats_q <= beats_d;
      tail_q  <= tail_d;
    end else if (beat_done_i) begin
      beats_q <= beats_q - BEAT_BITS'(1);
    end
  end

  assign last_beat_o = (beats_q == BEAT_BITS'(1));

  ////////////////////////////////////////
  // Tail byte enables
  ////////////////////////////////////////

  // Offset 1, 2, 3 keeps the lowest 1, 2, 3 bytes
  assign tail_be = ~({BYTES_PER_WORD{1'b1}} << tail_q);

  always_comb begin
    data_be_o = '1;
    if (last_beat_o && (tail_q != '0)) begin
      data_be_o = tail_be;
    end
  end

  // Sequencer must not retire more beats than were loaded
  a_no_underflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    beat_done_i |-> (beats_q != '0)
  ) else $error("beat_done with no beats remaining");

endmodule

//--- logic/vrf_pkg.sv
package vrf_pkg;

  ////////////////////////////////////////
  // Word geometry
  ////////////////////////////////////////

  // One register file word
  localparam int unsigned WORD_BITS = 32;
  localparam int unsigned BYTES_PER_WORD = 4;

  // Low bits of a byte count inside one word
  localparam int unsigned BYTE_OFFSET_BITS = 2;

  // Vector length and byte counts
  localparam int unsigned VL_BITS = 32;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Element width as a left shift of vl
  typedef enum logic [1:0] {
    SEW_8  = 2'd0,
    SEW_16 = 2'd1,
    SEW_32 = 2'd2
  } sew_e;

  // Sequencer states
  typedef enum logic [3:0] {
    IDLE       = 4'd0,
    START      = 4'd1,
    UN_READ    = 4'd2,
    UN_WRITE   = 4'd3,
    BIN_READ_A = 4'd4,
    BIN_READ_B = 4'd5,
    BIN_WRITE  = 4'd6,
    FILL_WRITE = 4'd7
  } vrf_state_e;

endpackage
